// File: cache_fill.f
verilog/cache_pkg.sv
verilog/line_fill_controller.sv
verilog/main_memory.sv
verilog/cache_tag_store.sv
verilog/cache_data_array.sv
verilog/cache_fill_top.sv
tb/cache_fill_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the cache fill testbench with Verilator and runs it once.

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module cache_fill_tb -f cache_fill.f -o cache_fill_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed."
  exit 1
fi

sim_output=$(./obj_dir/cache_fill_sim)
sim_status=$?
printf '%s\n' "$sim_output"

if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status."
  exit 1
fi

if printf '%s\n' "$sim_output" | grep -q "SIMULATION PASSED"; then
  exit 0
fi
echo "Pass message not found in the simulation output."
exit 1

// File: tb/cache_fill_tb.sv
`timescale 1ns/1ps

module cache_fill_tb
  import cache_pkg::*;
;

  localparam int MEM_LATENCY   = 4;  // Passed down to the DUT.
  localparam int RESET_CYCLES  = 16;
  localparam int PRELOAD_WORDS = 3 * WORDS_PER_LINE; // Three lines are preloaded.
  localparam int MAX_DELAY     = 5;  // Largest grant hold-off in the table.
  localparam int NUM_ENTRIES   = 21;
  localparam int TIMEOUT_CYCLES =
    NUM_ENTRIES * (MEM_LATENCY + 9 + MAX_DELAY + 8) + PRELOAD_WORDS + RESET_CYCLES;

  // One request of the table. A miss entry holds the grant low for hold cycles.
  typedef struct packed {
    addr_t addr;
    int    hold;
    logic  exp_hit;
  } stim_t;

  //////////////////////////////////////////////////////////////////////
  // Stimulus table. Line 0x1230 and line 0x5230 share set 0x23.
  //////////////////////////////////////////////////////////////////////
  localparam stim_t STIM [NUM_ENTRIES] = '{
    '{16'h1234, 3, 1'b0}, '{16'h1230, 0, 1'b1}, '{16'h1232, 0, 1'b1}, // Cold miss, then hits.
    '{16'h1236, 0, 1'b1}, '{16'h1238, 0, 1'b1}, '{16'h123a, 0, 1'b1},
    '{16'h123c, 0, 1'b1}, '{16'h123f, 0, 1'b1}, '{16'h0a86, 5, 1'b0}, // Second set filled.
    '{16'h1238, 0, 1'b1}, '{16'h0a80, 0, 1'b1}, '{16'h123e, 0, 1'b1}, // Interleaved hits.
    '{16'h0a8e, 0, 1'b1}, '{16'h0a83, 0, 1'b1}, '{16'h523a, 2, 1'b0}, // Same set, new tag.
    '{16'h5230, 0, 1'b1}, '{16'h0a82, 0, 1'b1}, '{16'h1232, 1, 1'b0}, // Old line is gone.
    '{16'h5234, 0, 1'b0}, '{16'h0a8c, 0, 1'b1}, '{16'h523e, 0, 1'b1}
  };

  logic        clk;
  logic        rst_n;
  logic        cpu_req;
  addr_t       cpu_addr;
  logic        proceed;
  logic        mem_load_en;
  addr_t       mem_load_addr;
  word_t       mem_load_data;
  logic        busy;
  logic        rd_valid;
  word_t       rd_data;
  logic        mem_en;
  word_t       model [MEM_WORDS];  // Expected main memory contents, word addressed.
  logic [31:0] lfsr_state;
  int          cycle_cnt;

  cache_fill_top #(
    .MEM_LATENCY(MEM_LATENCY)
  ) i_cache_fill_top (
    .clk(clk), .rst_n(rst_n), .cpu_req(cpu_req), .cpu_addr(cpu_addr), .proceed(proceed),
    .mem_load_en(mem_load_en), .mem_load_addr(mem_load_addr), .mem_load_data(mem_load_data),
    .busy(busy), .rd_valid(rd_valid), .rd_data(rd_data), .mem_en(mem_en)
  );

  always #20 clk = ~clk; // 40 ns period.

  // The run is bounded by the worst case length of every table entry.
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles.", TIMEOUT_CYCLES);
      $display("SIMULATION FAILED");
      $fatal(1, "Run stopped by the cycle limit.");
    end
  end

  task automatic report_failure(input string msg);
    $display("CHECK FAILED at %0d ns: %s", $time, msg);
    $display("SIMULATION FAILED");
    $fatal(1, "Stopping at the first failed check.");
  endtask

  // Galois form with taps 32, 22, 2 and 1.
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
  endfunction

  // One LFSR step per bit, so a word costs sixteen steps.
  task automatic draw_word(output word_t w);
    w = '0;
    for (int i = 0; i < 16; i++) begin
      w          = {lfsr_state[0], w[15:1]};
      lfsr_state = lfsr_step(lfsr_state);
    end
  endtask

  // Writes one line into main memory and records it in the model.
  task automatic preload_line(input addr_t base);
    addr_t a;
    word_t w;
    for (int i = 0; i < WORDS_PER_LINE; i++) begin
      a = base + addr_t'(2 * i);
      draw_word(w);
      model[a[15:1]] = w; // Byte lane bit plays no part in the word address.
      @(posedge clk);
      mem_load_en   <= 1'b1;
      mem_load_addr <= a;
      mem_load_data <= w;
    end
  endtask

  // Holds cpu_req for one cycle and stops at the negedge after the response edge.
  task automatic send_request(input addr_t a);
    @(posedge clk);
    cpu_req  <= 1'b1;
    cpu_addr <= a;
    @(posedge clk);
    cpu_req  <= 1'b0;
    @(negedge clk);
  endtask

  task automatic check_hit(input addr_t a);
    assert (rd_valid) else report_failure($sformatf("no rd_valid for hit at %h", a));
    assert (!busy) else report_failure($sformatf("busy high on hit at %h", a));
    assert (rd_data == model[a[15:1]])
      else report_failure($sformatf("rd_data %h at %h, expected %h", rd_data, a, model[a[15:1]]));
  endtask

  //////////////////////////////////////////////////////////////////////
  // Line fill after a miss, with the grant held off for hold cycles.
  //////////////////////////////////////////////////////////////////////
  task automatic run_fill(input int hold);
    int  k;
    logic done;
    for (int d = 0; d < hold; d++) begin
      @(negedge clk);
      assert (busy && !mem_en) else report_failure("mem_en rose before the grant");
    end
    @(posedge clk);
    proceed <= 1'b1; // Sampled by the controller at the next edge.
    k    = 0;
    done = 1'b0;
    while (!done) begin
      @(posedge clk);
      k++;
      if (k == 1) begin
        proceed <= 1'b0;
      end
      @(negedge clk);
      // mem_en must be high for exactly the eight cycles after the grant edge.
      assert (mem_en == (k >= 1 && k <= WORDS_PER_LINE))
        else report_failure($sformatf("mem_en is %b in fill cycle %0d", mem_en, k));
      done = !busy;
    end
    assert (k == MEM_LATENCY + 9)
      else report_failure($sformatf("busy fell %0d cycles after proceed", k));
  endtask

  initial begin
    clk           = 1'b0;
    rst_n         = 1'b0;
    cpu_req       = 1'b0;
    cpu_addr      = '0;
    proceed       = 1'b0;
    mem_load_en   = 1'b0;
    mem_load_addr = '0;
    mem_load_data = '0;
    lfsr_state    = 32'h4c96_01d5;
    cycle_cnt     = 0;

    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    assert (!busy && !mem_en && !rd_valid) else report_failure("outputs not idle after reset");

    preload_line(16'h1230);
    preload_line(16'h5230);
    preload_line(16'h0a80);
    @(posedge clk);
    mem_load_en <= 1'b0;

    // Every miss is filled and then reissued, which must then hit.
    for (int e = 0; e < NUM_ENTRIES; e++) begin
      send_request(STIM[e].addr);
      if (STIM[e].exp_hit) begin
        check_hit(STIM[e].addr);
      end else begin
        assert (busy && !rd_valid)
          else report_failure($sformatf("expected a miss at %h", STIM[e].addr));
        run_fill(STIM[e].hold);
        send_request(STIM[e].addr);
        check_hit(STIM[e].addr);
      end
    end

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

// File: verilog/cache_data_array.sv
`timescale 1ns/1ps

module cache_data_array
  import cache_pkg::*;
(
  input  logic       clk,
  input  logic       write_data_array,     // Fill write strobe.
  input  line_addr_t cache_memory_address, // Fill write address.
  input  word_t      memory_data,          // Fill word straight from main memory.
  input  addr_t      cpu_addr,             // Request address for the read side.
  output word_t      rd_data               // Word of the previous cycle's request.
);

  localparam int DEPTH = NUM_SETS * WORDS_PER_LINE; // 512 words.

  word_t mem [DEPTH];

  // Write port, used only by line fills.
  always_ff @(posedge clk) begin
    if (write_data_array) begin
      mem[cache_memory_address] <= memory_data;
    end
  end

  // Registered read. It runs every cycle, and rd_valid in the top level
  // says whether the word belongs to a hit.
  always_ff @(posedge clk) begin
    rd_data <= mem[addr_line(cpu_addr)];
  end

endmodule

// File: verilog/cache_fill_top.sv
`timescale 1ns/1ps

module cache_fill_top
  import cache_pkg::*;
#(
  parameter int MEM_LATENCY = 4 // Main memory read latency, 1 to 8.
) (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  cpu_req,       // Sampled while busy is low.
  input  addr_t cpu_addr,
  input  logic  proceed,       // Memory grant.
  input  logic  mem_load_en,   // Preload port into main memory.
  input  addr_t mem_load_addr,
  input  word_t mem_load_data,
  output logic  busy,          // A line fill is running.
  output logic  rd_valid,      // rd_data holds a hit word.
  output word_t rd_data,
  output logic  mem_en         // Read strobe, visible for grant timing.
);

  logic       hit;
  logic       miss_detected;
  addr_t      main_memory_address;
  logic       memory_data_valid;
  word_t      memory_data;
  logic       write_data_array;
  line_addr_t cache_memory_address;
  logic       write_tag_array;
  tag_t       tag_out;
  index_t     fill_index;

  // The eighth word's write address still carries the set of the line.
  assign fill_index = cache_memory_address[8:3];

  //////////////////////////////////////////////////////////////////////
  // Producer, buffer and consumers.
  //////////////////////////////////////////////////////////////////////
  line_fill_controller #(
    .MEM_LATENCY(MEM_LATENCY)
  ) i_line_fill_controller (
    .clk                 (clk),
    .rst_n               (rst_n),
    .proceed             (proceed),
    .miss_detected       (miss_detected),
    .miss_address        (cpu_addr),
    .memory_data_valid   (memory_data_valid),
    .busy                (busy),
    .mem_en              (mem_en),
    .main_memory_address (main_memory_address),
    .write_data_array    (write_data_array),
    .cache_memory_address(cache_memory_address),
    .write_tag_array     (write_tag_array),
    .tag_out             (tag_out)
  );

  main_memory #(
    .MEM_LATENCY(MEM_LATENCY)
  ) i_main_memory (
    .clk                (clk),
    .rst_n              (rst_n),
    .mem_en             (mem_en),
    .main_memory_address(main_memory_address),
    .mem_load_en        (mem_load_en),
    .mem_load_addr      (mem_load_addr),
    .mem_load_data      (mem_load_data),
    .memory_data_valid  (memory_data_valid),
    .memory_data        (memory_data)
  );

  cache_tag_store i_cache_tag_store (
    .clk            (clk),
    .rst_n          (rst_n),
    .cpu_req        (cpu_req),
    .cpu_addr       (cpu_addr),
    .busy           (busy),
    .write_tag_array(write_tag_array),
    .tag_out        (tag_out),
    .fill_index     (fill_index),
    .hit            (hit),
    .miss_detected  (miss_detected)
  );

  cache_data_array i_cache_data_array (
    .clk                 (clk),
    .write_data_array    (write_data_array),
    .cache_memory_address(cache_memory_address),
    .memory_data         (memory_data),
    .cpu_addr            (cpu_addr),
    .rd_data             (rd_data)
  );

  // Hit is delayed to line up with the registered read of the data array.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= hit;
    end
  end

endmodule

// File: verilog/cache_pkg.sv
package cache_pkg;

  //////////////////////////////////////////////////////////////////////
  // Cache geometry.
  //////////////////////////////////////////////////////////////////////
  localparam int WORDS_PER_LINE = 8;     // Sixteen-bit words in one cache line.
  localparam int NUM_SETS       = 64;    // Direct mapped, so one line per set.
  localparam int MEM_WORDS      = 32768; // Main memory covers the full 64 KB byte space.

  typedef logic [15:0] addr_t;      // Byte address from the CPU.
  typedef logic [15:0] word_t;      // One data word.
  typedef logic [6:0]  tag_t;       // Address bits 15:9.
  typedef logic [5:0]  index_t;     // Address bits 9:4, one of 64 sets.
  typedef logic [2:0]  offset_t;    // Address bits 3:1, word within the line.
  typedef logic [8:0]  line_addr_t; // Word address into the data array, {index, offset}.

  // Fill controller states.
  typedef enum logic [1:0] {
    FILL_IDLE, // Waiting for a miss.
    FILL_WAIT, // Miss captured, waiting for the memory grant.
    FILL_SEND  // Issuing reads and collecting returned words.
  } fill_state_t;

  // Bit 9 sits in both the tag and the index, so the tag compare covers it twice.
  function automatic tag_t addr_tag(addr_t a);
    return a[15:9];
  endfunction

  function automatic index_t addr_index(addr_t a);
    return a[9:4];
  endfunction

  function automatic offset_t addr_offset(addr_t a);
    return a[3:1]; // Bit 0 is the byte lane.
  endfunction

  // Data array word address of a byte address.
  function automatic line_addr_t addr_line(addr_t a);
    return {addr_index(a), addr_offset(a)};
  endfunction

  // First byte of the line that holds the address.
  function automatic addr_t addr_line_base(addr_t a);
    return {a[15:4], 4'h0};
  endfunction

endpackage

// File: verilog/cache_tag_store.sv
`timescale 1ns/1ps

module cache_tag_store
  import cache_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n,
  input  logic   cpu_req,         // Request strobe from the CPU.
  input  addr_t  cpu_addr,        // Request address.
  input  logic   busy,            // Requests are ignored while a fill runs.
  input  logic   write_tag_array, // Fill has completed.
  input  tag_t   tag_out,         // Tag of the filled line.
  input  index_t fill_index,      // Set of the filled line.
  output logic   hit,
  output logic   miss_detected
);

  tag_t                tags [NUM_SETS];
  logic [NUM_SETS-1:0] valid_bits;
  index_t              req_index;
  tag_t                req_tag;
  logic                entry_match; // Indexed entry is valid and holds the request tag.
  logic                req_taken;   // A request is accepted this cycle.

  assign req_index   = addr_index(cpu_addr);
  assign req_tag     = addr_tag(cpu_addr);
  assign entry_match = valid_bits[req_index] && (tags[req_index] == req_tag);
  assign req_taken   = cpu_req && !busy;

  // Exactly one of hit and miss_detected is high for an accepted request.
  assign hit           = req_taken && entry_match;
  assign miss_detected = req_taken && !entry_match;

  //////////////////////////////////////////////////////////////////////
  // Tag and valid storage.
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_bits <= '0; // Cache starts empty.
    end else if (write_tag_array) begin
      valid_bits[fill_index] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (write_tag_array) begin
      tags[fill_index] <= tag_out; // The old line in this set is replaced.
    end
  end

endmodule

// File: verilog/line_fill_controller.sv
`timescale 1ns/1ps

module line_fill_controller
  import cache_pkg::*;
#(
  parameter int MEM_LATENCY = 4 // Read latency of main memory in cycles.
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       proceed,              // Memory grant level.
  input  logic       miss_detected,        // Tag store saw a miss this cycle.
  input  addr_t      miss_address,         // Address of the missing request.
  input  logic       memory_data_valid,    // A fill word is on memory_data.
  output logic       busy,                 // Stalls the CPU while a line is filled.
  output logic       mem_en,               // Read strobe to main memory.
  output addr_t      main_memory_address,  // Byte address of the word being read.
  output logic       write_data_array,     // Write strobe into the data array.
  output line_addr_t cache_memory_address, // Data array address of the returning word.
  output logic       write_tag_array,      // Installs the tag once the line is complete.
  output tag_t       tag_out               // Tag of the line being filled.
);

  localparam int CNT_W = $clog2(WORDS_PER_LINE);
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(WORDS_PER_LINE - 1);

  fill_state_t      state;
  fill_state_t      nxt_state;
  logic [CNT_W-1:0] issue_cnt;   // Reads issued so far in this fill.
  logic [CNT_W-1:0] valid_cnt;   // Words returned so far in this fill.
  logic             capture;     // Latch the miss address and clear the counts.
  logic             set_busy;
  logic             clr_busy;
  logic             set_mem_en;
  logic             clr_mem_en;
  logic             last_word;   // The eighth word of the line is arriving.
  line_addr_t       addr_pipe [MEM_LATENCY];

  assign last_word = memory_data_valid && (valid_cnt == CNT_LAST);

  //////////////////////////////////////////////////////////////////////
  // Control flops.
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= FILL_IDLE;
      busy      <= 1'b0;
      mem_en    <= 1'b0;
      issue_cnt <= '0;
      valid_cnt <= '0;
    end else begin
      state <= nxt_state;
      // Busy and mem_en are set-reset flops, set wins.
      if (set_busy) begin
        busy <= 1'b1;
      end else if (clr_busy) begin
        busy <= 1'b0;
      end
      if (set_mem_en) begin
        mem_en <= 1'b1;
      end else if (clr_mem_en) begin
        mem_en <= 1'b0;
      end
      if (capture) begin
        issue_cnt <= '0;
      end else if (mem_en) begin
        issue_cnt <= issue_cnt + 1'b1; // One read goes out per enabled cycle.
      end
      if (capture) begin
        valid_cnt <= '0;
      end else if (write_data_array) begin
        valid_cnt <= valid_cnt + 1'b1;
      end
    end
  end

  // Line address and tag of the miss. The read address steps one word per issue.
  always_ff @(posedge clk) begin
    if (capture) begin
      main_memory_address <= addr_line_base(miss_address); // Fills always start at word 0.
      tag_out             <= addr_tag(miss_address);
    end else if (mem_en) begin
      main_memory_address <= main_memory_address + addr_t'(2);
    end
  end

  // Delay line matching the memory latency, so each returning word finds
  // the data array address it was read from.
  always_ff @(posedge clk) begin
    addr_pipe[0] <= addr_line(main_memory_address);
    for (int i = 1; i < MEM_LATENCY; i++) begin
      addr_pipe[i] <= addr_pipe[i-1];
    end
  end

  assign cache_memory_address = addr_pipe[MEM_LATENCY-1];

  //////////////////////////////////////////////////////////////////////
  // Next state and strobes.
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    nxt_state        = state; // Hold by default.
    capture          = 1'b0;
    set_busy         = 1'b0;
    clr_busy         = 1'b0;
    set_mem_en       = 1'b0;
    clr_mem_en       = 1'b0;
    write_data_array = 1'b0;
    write_tag_array  = 1'b0;

    case (state)
      FILL_IDLE: begin
        if (miss_detected) begin
          capture   = 1'b1;
          set_busy  = 1'b1;      // CPU sees busy on the next cycle.
          nxt_state = FILL_WAIT;
        end
      end

      FILL_WAIT: begin
        if (proceed) begin // Grant is only looked at here.
          set_mem_en = 1'b1;
          nxt_state  = FILL_SEND;
        end
      end

      FILL_SEND: begin
        clr_mem_en       = mem_en && (issue_cnt == CNT_LAST); // Stop after eight reads.
        write_data_array = memory_data_valid;                 // Every returning word is stored.
        if (last_word) begin
          write_tag_array = 1'b1; // Line is complete, so it becomes valid.
          clr_busy        = 1'b1;
          nxt_state       = FILL_IDLE;
        end
      end

      default: begin
        nxt_state = FILL_IDLE; // Unused encoding falls back to idle.
      end
    endcase
  end

endmodule

// File: verilog/main_memory.sv
`timescale 1ns/1ps

module main_memory
  import cache_pkg::*;
#(
  parameter int MEM_LATENCY = 4 // Cycles from mem_en to memory_data_valid.
) (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  mem_en,              // One read per cycle while high.
  input  addr_t main_memory_address, // Byte address of the read.
  input  logic  mem_load_en,         // Preload write strobe.
  input  addr_t mem_load_addr,       // Preload byte address.
  input  word_t mem_load_data,       // Preload word.
  output logic  memory_data_valid,   // Read data is on memory_data.
  output word_t memory_data
);

  localparam int WORD_AW = $clog2(MEM_WORDS); // Word address width, 15 bits.

  word_t                  mem       [MEM_WORDS];
  logic [MEM_LATENCY-1:0] valid_pipe;           // One bit per read in flight.
  word_t                  data_pipe [MEM_LATENCY];

  // Preload port. Only the testbench writes here.
  always_ff @(posedge clk) begin
    if (mem_load_en) begin
      mem[mem_load_addr[WORD_AW:1]] <= mem_load_data; // Byte lane bit is dropped.
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Read pipeline.
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_pipe <= '0;
    end else begin
      valid_pipe[0] <= mem_en;
      for (int i = 1; i < MEM_LATENCY; i++) begin
        valid_pipe[i] <= valid_pipe[i-1];
      end
    end
  end

  // The data stages shift alongside the valid stages, so several reads
  // can be in flight at once.
  always_ff @(posedge clk) begin
    data_pipe[0] <= mem[main_memory_address[WORD_AW:1]];
    for (int i = 1; i < MEM_LATENCY; i++) begin
      data_pipe[i] <= data_pipe[i-1];
    end
  end

  assign memory_data_valid = valid_pipe[MEM_LATENCY-1];
  assign memory_data       = data_pipe[MEM_LATENCY-1]; // Only meaningful with the valid strobe.

endmodule
